//--- design/optical_rx_pkg.sv
package optical_rx_pkg;

	//------------------------------------------------------------
	// Widths
	//------------------------------------------------------------
	typedef logic [15:0] rx_word_t;		// One link word
	typedef logic [47:0] frame_t;		// Comparator frame, three data words
	typedef logic [15:0] err_count_t;	// Reported error count
	typedef logic [7:0]  link_count_t;	// Link error count
	typedef logic [3:0]  delay_t;		// Output delay in clocks
	typedef logic [1:0]  reg_addr_t;	// Config register address

	// Frame sync FSM
	typedef enum logic [1:0] {
		SYNC_HUNT,		// Waiting for first good frame
		SYNC_CHECK,		// Counting good frames
		SYNC_LOCKED		// Aligned
	} sync_state_t;

	//------------------------------------------------------------
	// Link codes and thresholds
	//------------------------------------------------------------
	localparam rx_word_t FRAME_MARK    = 16'h50BC;		// K word, normal frame
	localparam rx_word_t FC_MARK       = 16'h50FC;		// K word, latency trigger frame
	localparam frame_t   START_PATTERN = {48{1'b1}};	// Start pattern frame

	localparam int WORDS_PER_FRAME = 3;	// Data words after the marker
	localparam int SYNC_FRAMES     = 4;	// Good frames to lock
	localparam int LOSS_ERRORS     = 4;	// Bad frames to drop lock

	localparam reg_addr_t REG_CTRL  = 2'd0;
	localparam reg_addr_t REG_CLEAR = 2'd1;

	// PRBS feedback mask, one shift per frame from bits 47 46 20 19
	localparam frame_t PRBS_TAPS = (48'd1 << 47) | (48'd1 << 46) | (48'd1 << 20) | (48'd1 << 19);

endpackage

//--- design/frame_aligner.sv
`timescale 1ns/1ps
module frame_aligner import optical_rx_pkg::*; (
	input  logic     clock,
	input  logic     gtx_rx_reset,
	input  rx_word_t rx_word,
	input  logic     rx_word_k,
	input  logic     rx_word_en,
	output frame_t   frame_data,
	output logic     frame_strobe,
	output logic     frame_error,
	output logic     rx_valid,
	output logic     rx_start,
	output logic     rx_fc,
	output logic     sync_done
);

	logic [1:0]  word_cnt;		// 0 = expecting marker
	logic [1:0]  word_cnt_nxt;
	logic [31:0] asm_data;		// First two data words
	logic        fc_frame;		// Current frame began with FC_MARK
	logic [2:0]  frame_cnt;		// Good frames in check, bad frames in lock
	logic [2:0]  frame_cnt_nxt;
	sync_state_t sync_state;
	sync_state_t sync_state_nxt;
	logic        is_marker;
	logic        frame_done;
	logic        bad_frame;
	frame_t      frame_full;

	assign is_marker  = rx_word_k && (rx_word == FRAME_MARK || rx_word == FC_MARK);
	assign frame_full = {asm_data, rx_word};	// First word lands in the top bits

	// Third clean data word closes the frame
	assign frame_done = rx_word_en && !rx_word_k && (word_cnt == 2'(WORDS_PER_FRAME));

	// K inside the data, or missing marker while locked
	assign bad_frame = rx_word_en && ((word_cnt != 2'd0 && rx_word_k) ||
		(word_cnt == 2'd0 && !is_marker && sync_state == SYNC_LOCKED));

	//------------------------------------------------------------
	// Word counter
	//------------------------------------------------------------
	always_comb begin
		word_cnt_nxt = word_cnt;
		if (rx_word_en) begin
			if (word_cnt == 2'd0 || rx_word_k)
				word_cnt_nxt = is_marker ? 2'd1 : 2'd0;	// A marker restarts the frame
			else if (frame_done)
				word_cnt_nxt = 2'd0;
			else
				word_cnt_nxt = word_cnt + 2'd1;
		end
	end

	//------------------------------------------------------------
	// Sync FSM next state
	//------------------------------------------------------------
	always_comb begin
		sync_state_nxt = sync_state;
		frame_cnt_nxt  = frame_cnt;
		case (sync_state)
			SYNC_HUNT: if (frame_done) begin
				sync_state_nxt = SYNC_CHECK;
				frame_cnt_nxt  = 3'd1;
			end
			SYNC_CHECK: begin
				if (bad_frame) begin			// Start over
					sync_state_nxt = SYNC_HUNT;
					frame_cnt_nxt  = 3'd0;
				end else if (frame_done) begin
					if (frame_cnt == 3'(SYNC_FRAMES - 1)) begin
						sync_state_nxt = SYNC_LOCKED;
						frame_cnt_nxt  = 3'd0;
					end else
						frame_cnt_nxt = frame_cnt + 3'd1;
				end
			end
			SYNC_LOCKED: begin
				if (bad_frame) begin
					if (frame_cnt == 3'(LOSS_ERRORS - 1)) begin	// Too many in a row
						sync_state_nxt = SYNC_HUNT;
						frame_cnt_nxt  = 3'd0;
					end else
						frame_cnt_nxt = frame_cnt + 3'd1;
				end else if (frame_done)
					frame_cnt_nxt = 3'd0;		// Good frame breaks the run
			end
			default: sync_state_nxt = SYNC_HUNT;
		endcase
	end

	// Frame payload
	always_ff @(posedge clock) begin
		if (rx_word_en && word_cnt != 2'd0 && !rx_word_k)
			asm_data <= {asm_data[15:0], rx_word};
		if (rx_word_en && is_marker)
			fc_frame <= (rx_word == FC_MARK);
	end

	always_ff @(posedge clock or posedge gtx_rx_reset) begin
		if (gtx_rx_reset) begin
			word_cnt     <= 2'd0;
			frame_cnt    <= 3'd0;
			sync_state   <= SYNC_HUNT;
			frame_data   <= '0;
			frame_strobe <= 1'b0;
			frame_error  <= 1'b0;
			rx_valid     <= 1'b0;
			rx_start     <= 1'b0;
			rx_fc        <= 1'b0;
		end else begin
			word_cnt     <= word_cnt_nxt;
			frame_cnt    <= frame_cnt_nxt;
			sync_state   <= sync_state_nxt;
			frame_strobe <= frame_done;
			frame_error  <= bad_frame;
			rx_valid     <= frame_done && (sync_state_nxt == SYNC_LOCKED);
			rx_start     <= frame_done && (frame_full == START_PATTERN);
			rx_fc        <= frame_done && fc_frame;
			if (frame_done)
				frame_data <= frame_full;	// Held until next frame
		end
	end

	assign sync_done = (sync_state == SYNC_LOCKED);	// Rises with the locking strobe

	// A frame is either delivered or flagged, never both
	assert property (@(posedge clock) disable iff (gtx_rx_reset) !(frame_strobe && frame_error))
		else $error("frame_aligner: strobe and error together");

endmodule

//--- design/prbs_checker.sv
`timescale 1ns/1ps
module prbs_checker import optical_rx_pkg::*; (
	input  logic       clock,
	input  logic       gtx_rx_reset,
	input  logic       prbs_en,
	input  logic       err_clear,
	input  logic       frame_strobe,
	input  logic       rx_valid,
	input  frame_t     frame_data,
	output logic       rx_match,
	output logic       rx_err,
	output err_count_t prbs_count
);

	frame_t prev_frame;		// Seed or last prediction
	frame_t expect_frame;
	logic   have_prev;		// Seed loaded
	logic   frame_ok;

	// One PRBS step per frame
	assign expect_frame = {prev_frame[46:0], ^(prev_frame & PRBS_TAPS)};
	assign frame_ok     = (frame_data == expect_frame);

	// First frame seeds, then the chain follows the prediction
	// so a single corrupt frame gives a single error
	always_ff @(posedge clock) begin
		if (frame_strobe)
			prev_frame <= have_prev ? expect_frame : frame_data;
	end

	always_ff @(posedge clock or posedge gtx_rx_reset) begin
		if (gtx_rx_reset) begin
			have_prev  <= 1'b0;
			rx_match   <= 1'b0;
			rx_err     <= 1'b0;
			prbs_count <= '0;
		end else begin
			rx_match <= 1'b0;
			rx_err   <= 1'b0;
			if (!prbs_en) begin		// Test off, drop seed and count
				have_prev  <= 1'b0;
				prbs_count <= '0;
			end else begin
				if (err_clear)
					prbs_count <= '0;
				if (frame_strobe) begin
					have_prev <= 1'b1;
					rx_match  <= frame_ok || !have_prev;	// Seed frame counts as a match
					if (rx_valid && have_prev && !frame_ok) begin
						rx_err <= 1'b1;
						if (!err_clear && prbs_count != '1)	// Saturate
							prbs_count <= prbs_count + 1'b1;
					end
				end
			end
		end
	end

	// Count only moves down through a clear or a disable
	assert property (@(posedge clock) disable iff (gtx_rx_reset)
		(prbs_en && !err_clear) |=> (prbs_count >= $past(prbs_count)))
		else $error("prbs_checker: count went down without a clear");

endmodule

//--- design/link_monitor.sv
`timescale 1ns/1ps
module link_monitor import optical_rx_pkg::*; (
	input  logic        clock,
	input  logic        gtx_rx_reset,
	input  logic        ttc_resync,
	input  logic        frame_strobe,
	input  logic        frame_error,
	input  logic        sync_done,
	output logic        link_good,
	output logic        link_bad,
	output logic        link_had_err,
	output link_count_t link_count
);

	logic had_err_nxt;

	// Sticky error flag, resync wins
	always_comb begin
		if (ttc_resync)
			had_err_nxt = 1'b0;
		else
			had_err_nxt = link_had_err || frame_error;
	end

	//------------------------------------------------------------
	// Status and error count
	//------------------------------------------------------------
	always_ff @(posedge clock or posedge gtx_rx_reset) begin
		if (gtx_rx_reset) begin
			link_good    <= 1'b0;
			link_bad     <= 1'b0;
			link_had_err <= 1'b0;
			link_count   <= '0;
		end else begin
			link_had_err <= had_err_nxt;

			if (ttc_resync)
				link_count <= '0;
			else if (frame_error && link_count != '1)
				link_count <= link_count + 1'b1;	// Saturating

			// Status follows each frame event or a resync
			if (frame_strobe || frame_error || ttc_resync) begin
				link_bad  <= !sync_done;
				link_good <= sync_done && !had_err_nxt;
			end
		end
	end

endmodule

//--- design/bx_delay_line.sv
`timescale 1ns/1ps
module bx_delay_line import optical_rx_pkg::*; (
	input  logic   clock,
	input  logic   gtx_rx_reset,
	input  delay_t delay,
	input  frame_t frame_data,
	output frame_t gtx_rx_data
);

	localparam int DEPTH = 15;	// Longest delay

	frame_t srl [DEPTH];		// srl[i] holds data i+1 clocks old
	delay_t tap_sel;
	logic   bypass;

	// Shift every clock
	always_ff @(posedge clock) begin
		srl[0] <= frame_data;
		for (int i = 1; i < DEPTH; i++)
			srl[i] <= srl[i - 1];
	end

	// Tap of delay minus one, zero delay goes straight through
	always_ff @(posedge clock or posedge gtx_rx_reset) begin
		if (gtx_rx_reset) begin
			tap_sel <= '0;
			bypass  <= 1'b1;
		end else begin
			tap_sel <= delay - 4'd1;
			bypass  <= (delay == 4'd0);
		end
	end

	assign gtx_rx_data = bypass ? frame_data : srl[tap_sel];

endmodule

//--- design/optical_rx_regs.sv
`timescale 1ns/1ps
module optical_rx_regs import optical_rx_pkg::*; (
	input  logic        clock,
	input  logic        gtx_rx_reset,
	input  logic        cfg_wr,
	input  reg_addr_t   cfg_addr,
	input  rx_word_t    cfg_wdata,
	input  err_count_t  prbs_count,
	input  link_count_t link_count,
	output rx_word_t    cfg_rdata,
	output logic        prbs_en,
	output delay_t      delay,
	output logic        err_clear,
	output err_count_t  gtx_rx_err_count
);

	rx_word_t ctrl_reg;		// [0] prbs_en, [7:4] delay

	//------------------------------------------------------------
	// Control register and clear strobe
	//------------------------------------------------------------
	always_ff @(posedge clock or posedge gtx_rx_reset) begin
		if (gtx_rx_reset) begin
			ctrl_reg  <= '0;
			err_clear <= 1'b0;
		end else begin
			if (cfg_wr && cfg_addr == REG_CTRL)
				ctrl_reg <= cfg_wdata;
			err_clear <= cfg_wr && (cfg_addr == REG_CLEAR);	// One clock per write
		end
	end

	assign prbs_en   = ctrl_reg[0];
	assign delay     = ctrl_reg[7:4];
	assign cfg_rdata = ctrl_reg;	// Same value at every address

	//------------------------------------------------------------
	// Reported error count
	//------------------------------------------------------------
	always_ff @(posedge clock or posedge gtx_rx_reset) begin
		if (gtx_rx_reset)
			gtx_rx_err_count <= '0;
		else if (prbs_en)
			gtx_rx_err_count <= prbs_count;
		else
			gtx_rx_err_count <= {8'h00, link_count};	// Link count, zero extended
	end

endmodule

//--- design/gtx_optical_rx.sv
`timescale 1ns/1ps
module gtx_optical_rx import optical_rx_pkg::*; (
	input  logic       clock,
	input  logic       gtx_rx_reset,
	input  logic       ttc_resync,		// Clears link status
	input  rx_word_t   rx_word,
	input  logic       rx_word_k,
	input  logic       rx_word_en,
	input  logic       cfg_wr,
	input  reg_addr_t  cfg_addr,
	input  rx_word_t   cfg_wdata,
	output rx_word_t   cfg_rdata,
	output frame_t     gtx_rx_data,		// Delayed comparator data
	output logic       gtx_rx_start,
	output logic       gtx_rx_fc,
	output logic       gtx_rx_valid,
	output logic       gtx_rx_match,
	output logic       gtx_rx_sync_done,
	output logic       gtx_rx_err,
	output err_count_t gtx_rx_err_count,
	output logic       link_good,
	output logic       link_bad,
	output logic       link_had_err
);

	frame_t      frame_data;
	logic        frame_strobe;
	logic        frame_error;
	logic        prbs_en;
	logic        err_clear;
	delay_t      delay;
	err_count_t  prbs_count;
	link_count_t link_count;

	//------------------------------------------------------------
	// Receive path
	//------------------------------------------------------------
	frame_aligner i_frame_aligner (
		.clock, .gtx_rx_reset, .rx_word, .rx_word_k, .rx_word_en,
		.frame_data, .frame_strobe, .frame_error,
		.rx_valid  (gtx_rx_valid),
		.rx_start  (gtx_rx_start),
		.rx_fc     (gtx_rx_fc),
		.sync_done (gtx_rx_sync_done)
	);

	prbs_checker i_prbs_checker (
		.clock, .gtx_rx_reset, .prbs_en, .err_clear, .frame_strobe,
		.rx_valid (gtx_rx_valid),
		.frame_data,
		.rx_match (gtx_rx_match),
		.rx_err   (gtx_rx_err),
		.prbs_count
	);

	link_monitor i_link_monitor (
		.clock, .gtx_rx_reset, .ttc_resync, .frame_strobe, .frame_error,
		.sync_done (gtx_rx_sync_done),
		.link_good, .link_bad, .link_had_err, .link_count
	);

	bx_delay_line i_bx_delay_line (
		.clock, .gtx_rx_reset, .delay, .frame_data, .gtx_rx_data
	);

	// Config and count select
	optical_rx_regs i_optical_rx_regs (
		.clock, .gtx_rx_reset, .cfg_wr, .cfg_addr, .cfg_wdata,
		.prbs_count, .link_count,
		.cfg_rdata, .prbs_en, .delay, .err_clear, .gtx_rx_err_count
	);

endmodule

//--- dv/tb_gtx_optical_rx.sv
`timescale 1ns/1ps
module tb_gtx_optical_rx import optical_rx_pkg::*; ();

	logic       clock;
	logic       gtx_rx_reset;
	logic       ttc_resync;
	rx_word_t   rx_word;
	logic       rx_word_k;
	logic       rx_word_en;
	logic       cfg_wr;
	reg_addr_t  cfg_addr;
	rx_word_t   cfg_wdata;
	rx_word_t   cfg_rdata;
	frame_t     gtx_rx_data;
	logic       gtx_rx_start;
	logic       gtx_rx_fc;
	logic       gtx_rx_valid;
	logic       gtx_rx_match;
	logic       gtx_rx_sync_done;
	logic       gtx_rx_err;
	err_count_t gtx_rx_err_count;
	logic       link_good;
	logic       link_bad;
	logic       link_had_err;

	int          errors = 0;
	int          checks = 0;
	int          tests  = 0;
	logic [31:0] rng_state = 32'h78de;
	frame_t      last_frame = '0;		// Frame the aligner holds now
	logic        seen_valid;
	logic        seen_start;
	logic        seen_fc;
	logic        seen_match;
	logic        seen_err;

	gtx_optical_rx i_gtx_optical_rx (.*);

	initial clock = 1'b0;
	always #10 clock = ~clock;		// 20 ns period

	//------------------------------------------------------------
	// Stimulus and reference helpers
	//------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic frame_t random_frame();
		frame_t f;
		rng_state = xorshift32(rng_state);
		f[47:16]  = rng_state;
		rng_state = xorshift32(rng_state);
		f[15:0]   = rng_state[15:0];
		return f;
	endfunction

	// PRBS model shifting left with feedback from bits 47 46 20 19
	function automatic frame_t prbs_next(input frame_t f);
		return {f[46:0], f[47] ^ f[46] ^ f[20] ^ f[19]};
	endfunction

	task automatic check_value(input string test, input string what,
			input frame_t exp, input frame_t act);
		checks++;
		assert (exp === act) else begin
			$display("[ERROR] %s %s: expected %h, actual %h", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic drive_word(input rx_word_t w, input logic k);
		@(negedge clock);
		rx_word    <= w;
		rx_word_k  <= k;
		rx_word_en <= 1'b1;
	endtask

	// Marker and three data words with a K on the last one when bad is set
	task automatic send_frame(input rx_word_t mark, input frame_t data, input logic bad);
		{seen_valid, seen_start, seen_fc, seen_match, seen_err} = '0;
		drive_word(mark, 1'b1);
		drive_word(data[47:32], 1'b0);
		drive_word(data[31:16], 1'b0);
		drive_word(data[15:0], bad);
		repeat (3) begin		// Strobe, then PRBS result, then count
			@(negedge clock);
			rx_word_en <= 1'b0;
			seen_valid = seen_valid | gtx_rx_valid;
			seen_start = seen_start | gtx_rx_start;
			seen_fc    = seen_fc | gtx_rx_fc;
			seen_match = seen_match | gtx_rx_match;
			seen_err   = seen_err | gtx_rx_err;
		end
		if (!bad)
			last_frame = data;
	endtask

	task automatic write_reg(input reg_addr_t addr, input rx_word_t data);
		@(negedge clock);
		cfg_wr    <= 1'b1;
		cfg_addr  <= addr;
		cfg_wdata <= data;
		@(negedge clock);
		cfg_wr <= 1'b0;
	endtask

	task automatic wait_count_zero(input string test);
		int n;
		n = 0;
		while (gtx_rx_err_count != '0 && n < 20) begin
			@(negedge clock);
			n++;
		end
		checks++;
		assert (gtx_rx_err_count == '0) else begin
			$display("%s: error count did not return to zero before the timeout", test);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests++;
		$display("test %-6s done, %0d errors", name, errors - errs_before);
	endtask

	//------------------------------------------------------------
	// Directed tests
	//------------------------------------------------------------
	task automatic test_sync_valid();
		int     e0;
		int     n;
		frame_t d;
		e0 = errors;
		check_value("sync", "flags after reset", '0, {gtx_rx_start, gtx_rx_fc, gtx_rx_valid,
			gtx_rx_match, gtx_rx_sync_done, gtx_rx_err, link_good, link_bad, link_had_err});
		check_value("sync", "count after reset", '0, gtx_rx_err_count);
		check_value("sync", "ctrl after reset", '0, cfg_rdata);
		for (int i = 0; i < SYNC_FRAMES; i++) begin
			send_frame(FRAME_MARK, random_frame(), 1'b0);
			check_value("sync", "valid", i == SYNC_FRAMES - 1, seen_valid);	// Lock frame is valid
		end
		n = 0;
		while (!link_good && n < 20) begin
			@(negedge clock);
			n++;
		end
		assert (link_good) else begin
			$display("sync: link_good did not rise before the timeout");
			errors++;
		end
		check_value("sync", "sync_done", 1, gtx_rx_sync_done);
		repeat (3) begin
			d = random_frame();
			send_frame(FRAME_MARK, d, 1'b0);
			check_value("sync", "valid", 1, seen_valid);
			check_value("sync", "data", d, gtx_rx_data);		// Delay is zero
		end
		end_test("sync", e0);
	endtask

	task automatic test_start_fc();
		int e0;
		e0 = errors;
		send_frame(FRAME_MARK, START_PATTERN, 1'b0);
		check_value("flags", "start/fc", 2'b10, {seen_start, seen_fc});
		send_frame(FC_MARK, random_frame(), 1'b0);
		check_value("flags", "start/fc", 2'b01, {seen_start, seen_fc});
		send_frame(FRAME_MARK, random_frame(), 1'b0);
		check_value("flags", "start/fc", 2'b00, {seen_start, seen_fc});
		end_test("flags", e0);
	endtask

	task automatic test_prbs();
		int     e0;
		int     pulses;
		logic   corrupt;
		frame_t f;
		e0 = errors;
		pulses = 0;
		write_reg(REG_CTRL, 16'h0001);	// PRBS on, no delay
		check_value("prbs", "ctrl readback", 16'h0001, cfg_rdata);
		f = random_frame();				// Seed frame
		repeat (6) begin
			send_frame(FRAME_MARK, f, 1'b0);
			check_value("prbs", "match", 1, seen_match);
			f = prbs_next(f);
		end
		check_value("prbs", "clean count", 0, gtx_rx_err_count);
		for (int i = 0; i < 8; i++) begin
			corrupt = (i == 2 || i == 5);
			send_frame(FRAME_MARK, corrupt ? f ^ (48'd1 << (i * 5)) : f, 1'b0);
			check_value("prbs", "match", !corrupt, seen_match);
			pulses += seen_err;
			f = prbs_next(f);			// Model follows the clean sequence
		end
		check_value("prbs", "err pulses", 2, pulses);
		check_value("prbs", "count", 2, gtx_rx_err_count);
		write_reg(REG_CLEAR, 16'h0000);
		check_value("prbs", "ctrl at clear address", 16'h0001, cfg_rdata);	// Clear leaves ctrl
		wait_count_zero("prbs");
		end_test("prbs", e0);
	endtask

	task automatic test_link();
		int e0;
		e0 = errors;
		write_reg(REG_CTRL, 16'h0000);	// Count select shows the link count
		send_frame(FRAME_MARK, random_frame(), 1'b1);
		send_frame(FRAME_MARK, random_frame(), 1'b0);
		send_frame(FRAME_MARK, random_frame(), 1'b1);
		send_frame(FRAME_MARK, random_frame(), 1'b0);	// Breaks the error run
		check_value("link", "had_err", 1, link_had_err);
		check_value("link", "link_good", 0, link_good);
		check_value("link", "count", 2, gtx_rx_err_count);
		for (int i = 0; i < LOSS_ERRORS; i++) begin
			check_value("link", "sync_done before error", 1, gtx_rx_sync_done);
			send_frame(FRAME_MARK, random_frame(), 1'b1);
		end
		check_value("link", "sync_done after loss", 0, gtx_rx_sync_done);
		check_value("link", "link_bad", 1, link_bad);
		check_value("link", "count", 2 + LOSS_ERRORS, gtx_rx_err_count);
		@(negedge clock);
		ttc_resync <= 1'b1;
		@(negedge clock);
		ttc_resync <= 1'b0;
		wait_count_zero("link");
		check_value("link", "had_err after resync", 0, link_had_err);
		end_test("link", e0);
	endtask

	// Frames stream back to back while the output is compared every clock
	task automatic test_delay();
		int     e0;
		int     d;
		frame_t f;
		frame_t cur;
		frame_t hist[$];
		e0 = errors;
		for (int k = 0; k < 3; k++) begin
			d = (k == 0) ? 0 : (k == 1) ? 3 : 9;
			write_reg(REG_CTRL, 16'(d << 4));
			hist.delete();
			cur = last_frame;
			for (int n = 0; n < 6; n++) begin
				f = random_frame();
				for (int w = 0; w < 4; w++) begin
					@(negedge clock);
					hist.push_back(cur);		// Aligner output during this clock
					if (hist.size() > d)
						check_value("delay", "data", hist[hist.size() - 1 - d], gtx_rx_data);
					rx_word    <= (w == 0) ? FRAME_MARK : 16'(f >> (16 * (3 - w)));
					rx_word_k  <= (w == 0);
					rx_word_en <= 1'b1;
					if (w == 3)
						cur = f;		// Taken at the next rising edge
				end
			end
			@(negedge clock);
			rx_word_en <= 1'b0;
			last_frame = cur;
		end
		end_test("delay", e0);
	endtask

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------
	initial begin
		gtx_rx_reset = 1'b1;
		ttc_resync   = 1'b0;
		rx_word      = '0;
		rx_word_k    = 1'b0;
		rx_word_en   = 1'b0;
		cfg_wr       = 1'b0;
		cfg_addr     = '0;
		cfg_wdata    = '0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		gtx_rx_reset = 1'b0;
		test_sync_valid();
		test_start_fc();
		test_prbs();
		test_link();
		test_delay();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- sim.f
design/optical_rx_pkg.sv
design/frame_aligner.sv
design/prbs_checker.sv
design/link_monitor.sv
design/bx_delay_line.sv
design/optical_rx_regs.sv
design/gtx_optical_rx.sv
dv/tb_gtx_optical_rx.sv
